// File: rtl/scc_defs.svh
`ifndef SCC_DEFS_SVH
`define SCC_DEFS_SVH

`define SCC_BYTE_W 8   // data and register width
`define SCC_TC_W 16    // time constant {wr13, wr12}

// write register indices, channel a
`define SCC_R_WR0 4'd0
`define SCC_R_WR1 4'd1
`define SCC_R_WR3 4'd3
`define SCC_R_WR4 4'd4
`define SCC_R_WR5 4'd5
`define SCC_R_WR9 4'd9
`define SCC_R_TC_LO 4'd12
`define SCC_R_TC_HI 4'd13

// read register indices
`define SCC_R_RR0 4'd0
`define SCC_R_RR1 4'd1
`define SCC_R_RR3 4'd3
`define SCC_R_RR8 4'd8

`define SCC_CMD_POINT_HI 3'b001   // wr0[5:3]
`define SCC_CMD_RX_FIRST 3'b100   // enable int on next rx char
`define SCC_CMD_RST_TXIP 3'b101

`define SCC_RST_CHAN_A 2'b10      // wr9[7:6]
`define SCC_RST_HW 2'b11

// bit positions inside the write registers
`define SCC_WR1_TXIE 1
`define SCC_WR1_RXMODE_LO 3       // rx int mode in [4:3]
`define SCC_WR3_RXEN 0
`define SCC_WR3_BITS_LO 6         // rx bits/char in [7:6]
`define SCC_WR4_STOP_LO 2         // stop mode in [3:2]
`define SCC_WR5_TXEN 3
`define SCC_WR5_BITS_LO 5         // tx bits/char in [6:5]
`define SCC_WR9_MIE 3

`endif

// File: rtl/scc_pkg.sv
`default_nettype none
`include "scc_defs.svh"

package scc_pkg;

	typedef logic [`SCC_BYTE_W-1:0] byte_t;	// register or data value
	typedef logic [3:0] reg_index_t;	// bit 3 comes from point high

	// scc's own bits/char encoding, same in wr3 and wr5
	typedef enum logic [1:0] {
		LEN_5 = 2'b00,
		LEN_7 = 2'b01,
		LEN_6 = 2'b10,
		LEN_8 = 2'b11
	} char_len_t;

	typedef enum logic [1:0] {
		RX_INT_OFF = 2'b00,
		RX_INT_FIRST = 2'b01,	// first char or special
		RX_INT_ALL = 2'b10,	// every char or special
		RX_INT_SPECIAL = 2'b11	// special only, nothing special is left here
	} rx_mode_t;

	typedef logic [`SCC_TC_W-1:0] time_const_t;

	// data bits in one character
	function automatic logic [3:0] char_bits(char_len_t len);
		case (len)
			LEN_5: char_bits = 4'd5;
			LEN_6: char_bits = 4'd6;
			LEN_7: char_bits = 4'd7;
			default: char_bits = 4'd8;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: rtl/scc_bus_regs.sv
`default_nettype none
`include "scc_defs.svh"

module scc_bus_regs (
	input wire clk,
	input wire reset_hw,
	input wire i_cs,
	input wire i_we,
	input wire [1:0] i_rs,	// [1] data/ctl, [0] a/b side
	input wire scc_pkg::byte_t i_wdata,
	input wire i_rx_valid,
	input wire scc_pkg::byte_t i_rx_data,
	input wire i_tx_ready,
	input wire i_tx_busy,
	input wire i_rx_ip,
	input wire i_tx_ip,
	output scc_pkg::byte_t o_rdata,
	output logic o_tx_valid,
	output scc_pkg::byte_t o_tx_data,
	output logic o_chan_reset,
	output logic o_cmd_rx_first,
	output logic o_cmd_rst_txip,
	output logic o_data_write,
	output logic o_data_read,
	output logic o_rx_en,
	output scc_pkg::char_len_t o_rx_len,
	output scc_pkg::rx_mode_t o_rx_mode,
	output logic o_two_stop,
	output logic o_tx_en,
	output scc_pkg::char_len_t o_tx_len,
	output logic o_tx_ie,
	output logic o_mie,
	output scc_pkg::time_const_t o_tc
);

	scc_pkg::reg_index_t rindex;	// pointer seen by the current access
	scc_pkg::reg_index_t rindex_next;	// pointer for the following access
	scc_pkg::byte_t wr1;
	scc_pkg::byte_t wr3;
	scc_pkg::byte_t wr4;
	scc_pkg::byte_t wr5;
	scc_pkg::byte_t wr9;
	scc_pkg::byte_t wr12;
	scc_pkg::byte_t wr13;
	scc_pkg::byte_t rx_hold;	// last received char
	scc_pkg::byte_t tx_data;
	logic rx_avail;
	logic tx_valid;
	logic tx_take;
	logic ctl_acc;
	logic ctl_wr;
	logic wr0_wr;
	logic wr9_wr;
	logic rst_hw_cmd;
	logic [2:0] wr0_cmd;
	logic [1:0] wr9_rst;

	// only channel a is decoded, b side is ignored
	assign ctl_acc = i_cs & ~i_rs[1] & i_rs[0];
	assign ctl_wr = ctl_acc & i_we;
	assign o_data_write = i_cs & i_we & i_rs[1] & i_rs[0];
	assign o_data_read = i_cs & ~i_we & i_rs[1] & i_rs[0];

	assign wr0_cmd = i_wdata[5:3];
	assign wr0_wr = ctl_wr & (rindex == `SCC_R_WR0);
	assign o_cmd_rx_first = wr0_wr & (wr0_cmd == `SCC_CMD_RX_FIRST);
	assign o_cmd_rst_txip = wr0_wr & (wr0_cmd == `SCC_CMD_RST_TXIP);

	assign wr9_rst = i_wdata[7:6];
	assign wr9_wr = ctl_wr & (rindex == `SCC_R_WR9);
	assign rst_hw_cmd = wr9_wr & (wr9_rst == `SCC_RST_HW);
	assign o_chan_reset = rst_hw_cmd | (wr9_wr & (wr9_rst == `SCC_RST_CHAN_A));	// one clk

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rindex_next <= '0;
			rindex <= '0;
		end else begin
			if (ctl_acc) begin
				rindex_next <= '0;	// back to wr0 after any control access
				if (wr0_wr)
					rindex_next <= {(wr0_cmd == `SCC_CMD_POINT_HI), i_wdata[2:0]};
			end
			// pointer moves only between accesses so read data holds still
			if (!i_cs)
				rindex <= rindex_next;
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			wr1 <= '0;
			wr3 <= '0;
			wr4 <= '0;
			wr5 <= '0;
			wr9 <= '0;
			wr12 <= '0;
			wr13 <= '0;
		end else if (o_chan_reset) begin
			wr1 <= '0;
			wr5[`SCC_WR5_TXEN] <= 1'b0;	// wr3, wr4, tc survive
			if (rst_hw_cmd)
				wr9[`SCC_WR9_MIE] <= 1'b0;	// hw reset also drops mie
		end else if (ctl_wr) begin
			case (rindex)
				`SCC_R_WR1: wr1 <= i_wdata;
				`SCC_R_WR3: wr3 <= i_wdata;
				`SCC_R_WR4: wr4 <= i_wdata;
				`SCC_R_WR5: wr5 <= i_wdata;
				`SCC_R_WR9: wr9 <= {2'b00, i_wdata[5:0]};	// top bits are commands
				`SCC_R_TC_LO: wr12 <= i_wdata;
				`SCC_R_TC_HI: wr13 <= i_wdata;
				default: ;
			endcase
		end
	end

	// tx buffer, a second write just replaces the byte
	assign tx_take = tx_valid & i_tx_ready;

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			tx_valid <= 1'b0;
			tx_data <= '0;
		end else if (o_chan_reset) begin
			tx_valid <= 1'b0;
		end else if (o_data_write) begin
			tx_valid <= 1'b1;
			tx_data <= i_wdata;
		end else if (tx_take) begin
			tx_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rx_hold <= '0;
			rx_avail <= 1'b0;
		end else if (i_rx_valid) begin
			rx_hold <= i_rx_data;	// unread char is simply overwritten
			rx_avail <= 1'b1;
		end else if (o_data_read || o_chan_reset) begin
			rx_avail <= 1'b0;
		end
	end

	always_comb begin
		o_rdata = '0;
		if (i_rs[0]) begin	// b side reads zero
			if (i_rs[1]) begin
				o_rdata = rx_hold;
			end else begin
				case (rindex)
					`SCC_R_RR0: begin
						o_rdata[0] = rx_avail;
						o_rdata[2] = ~tx_valid;	// tx buffer empty
					end
					`SCC_R_RR1: o_rdata[0] = ~tx_valid & ~i_tx_busy;	// all sent
					`SCC_R_RR3: begin
						o_rdata[5] = i_rx_ip;
						o_rdata[4] = i_tx_ip;
					end
					`SCC_R_RR8: o_rdata = rx_hold;
					`SCC_R_TC_LO: o_rdata = wr12;
					`SCC_R_TC_HI: o_rdata = wr13;
					default: o_rdata = '0;
				endcase
			end
		end
	end

	assign o_tx_valid = tx_valid;
	assign o_tx_data = tx_data;
	assign o_rx_en = wr3[`SCC_WR3_RXEN];
	assign o_rx_len = scc_pkg::char_len_t'(wr3[`SCC_WR3_BITS_LO +: 2]);
	assign o_rx_mode = scc_pkg::rx_mode_t'(wr1[`SCC_WR1_RXMODE_LO +: 2]);
	assign o_two_stop = (wr4[`SCC_WR4_STOP_LO +: 2] == 2'b11);	// 01 and 10 give one
	assign o_tx_en = wr5[`SCC_WR5_TXEN];
	assign o_tx_len = scc_pkg::char_len_t'(wr5[`SCC_WR5_BITS_LO +: 2]);
	assign o_tx_ie = wr1[`SCC_WR1_TXIE];
	assign o_mie = wr9[`SCC_WR9_MIE];
	assign o_tc = {wr13, wr12};

endmodule

`default_nettype wire

// File: rtl/scc_tx.sv
`default_nettype none
`include "scc_defs.svh"

module scc_tx (
	input wire clk,
	input wire reset_hw,
	input wire i_tx_valid,
	input wire scc_pkg::byte_t i_tx_data,
	input wire i_chan_reset,
	input wire i_tx_en,
	input wire scc_pkg::char_len_t i_tx_len,
	input wire i_two_stop,
	input wire scc_pkg::time_const_t i_tc,
	output logic o_tx_ready,
	output logic o_tx_busy,
	output logic o_txd
);

	localparam int HALF_W = `SCC_TC_W + 1;
	localparam int CNT_W = `SCC_TC_W + 2;

	logic [HALF_W-1:0] half_period;
	logic [CNT_W-1:0] bit_period;
	logic [CNT_W-1:0] bit_cnt;
	logic [3:0] n_data;
	logic [3:0] bits_left;	// bits still to send after the current one
	logic [9:0] shreg;	// data then stop bits, lsb goes next
	scc_pkg::byte_t data_fill;
	logic busy;
	logic take;
	logic bit_end;

	assign half_period = {1'b0, i_tc} + HALF_W'(2);
	assign bit_period = {half_period, 1'b0};	// 2*(tc+2)
	assign bit_end = (bit_cnt == bit_period - 1'b1);

	assign n_data = scc_pkg::char_bits(i_tx_len);
	// unused high data bits become stop level
	assign data_fill = i_tx_data | ~(8'hff >> (4'd8 - n_data));

	assign o_tx_ready = ~busy & i_tx_en;
	assign o_tx_busy = busy;
	assign take = i_tx_valid & o_tx_ready;

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			busy <= 1'b0;
			bit_cnt <= '0;
			bits_left <= '0;
			o_txd <= 1'b1;	// idle mark
		end else if (i_chan_reset) begin
			busy <= 1'b0;
			bit_cnt <= '0;
			bits_left <= '0;
			o_txd <= 1'b1;
		end else if (take) begin
			busy <= 1'b1;
			bit_cnt <= '0;
			bits_left <= n_data + (i_two_stop ? 4'd2 : 4'd1);
			o_txd <= 1'b0;	// start bit
		end else if (busy) begin
			if (bit_end) begin
				bit_cnt <= '0;
				if (bits_left == 4'd0) begin
					busy <= 1'b0;	// last stop bit done
				end else begin
					o_txd <= shreg[0];
					bits_left <= bits_left - 4'd1;
				end
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			shreg <= {2'b11, data_fill};
		else if (busy && bit_end)
			shreg <= {1'b1, shreg[9:1]};	// shift in mark
	end

endmodule

`default_nettype wire

// File: rtl/scc_rx.sv
`default_nettype none
`include "scc_defs.svh"

module scc_rx (
	input wire clk,
	input wire reset_hw,
	input wire i_rxd,
	input wire i_chan_reset,
	input wire i_rx_en,
	input wire scc_pkg::char_len_t i_rx_len,
	input wire scc_pkg::time_const_t i_tc,
	output logic o_rx_valid,
	output scc_pkg::byte_t o_rx_data
);

	localparam int HALF_W = `SCC_TC_W + 1;
	localparam int CNT_W = `SCC_TC_W + 2;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,	// waiting for mid start bit
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	logic rxd_meta;
	logic rxd_sync;
	logic [HALF_W-1:0] half_period;
	logic [CNT_W-1:0] bit_period;
	logic [CNT_W-1:0] cnt;
	logic [3:0] n_data;
	logic [2:0] bit_idx;
	scc_pkg::byte_t shreg;	// bits enter at the top
	logic half_end;
	logic bit_end;

	assign half_period = {1'b0, i_tc} + HALF_W'(2);
	assign bit_period = {half_period, 1'b0};
	assign half_end = (cnt == {1'b0, half_period} - 1'b1);
	assign bit_end = (cnt == bit_period - 1'b1);
	assign n_data = scc_pkg::char_bits(i_rx_len);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= i_rxd;	// async line, two flops
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			state <= RX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			o_rx_valid <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0;
			if (i_chan_reset || !i_rx_en) begin
				state <= RX_IDLE;
				cnt <= '0;
			end else begin
				case (state)
					RX_IDLE: begin
						cnt <= '0;
						if (!rxd_sync)
							state <= RX_START;	// falling edge
					end
					RX_START: begin
						if (half_end) begin
							cnt <= '0;
							bit_idx <= '0;
							state <= rxd_sync ? RX_IDLE : RX_DATA;	// glitch goes back
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					RX_DATA: begin
						if (bit_end) begin
							cnt <= '0;
							bit_idx <= bit_idx + 3'd1;
							if ({1'b0, bit_idx} == n_data - 4'd1)
								state <= RX_STOP;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					default: begin
						if (bit_end) begin
							cnt <= '0;
							state <= RX_IDLE;
							o_rx_valid <= rxd_sync;	// framing error drops the char
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end)
			shreg <= {rxd_sync, shreg[7:1]};	// lsb first
		if (state == RX_STOP && bit_end)
			o_rx_data <= shreg >> (4'd8 - n_data);	// right align, zero top
	end

endmodule

`default_nettype wire

// File: rtl/scc_irq.sv
`default_nettype none

module scc_irq (
	input wire clk,
	input wire reset_hw,
	input wire i_rx_avail_set,
	input wire i_data_read,
	input wire i_data_write,
	input wire i_cmd_rx_first,
	input wire i_cmd_rst_txip,
	input wire i_chan_reset,
	input wire i_rx_en,
	input wire scc_pkg::rx_mode_t i_rx_mode,
	input wire i_tx_ie,
	input wire i_mie,
	input wire i_tx_valid,
	input wire i_tx_ready,
	output logic o_rx_ip,
	output logic o_tx_ip,
	output logic o_irq_n
);

	logic rx_first;	// next char is the first one
	logic tx_take;
	logic rx_hit;
	logic rx_ip_d;
	logic tx_ip_d;

	assign tx_take = i_tx_valid & i_tx_ready;	// buffer went to the shifter

	// mode 01 fires only while first is armed, mode 10 on every char
	assign rx_hit = i_rx_avail_set & i_rx_en &
		((i_rx_mode == scc_pkg::RX_INT_ALL) ||
		 ((i_rx_mode == scc_pkg::RX_INT_FIRST) && rx_first));

	always_comb begin
		rx_ip_d = o_rx_ip;
		if (i_chan_reset)
			rx_ip_d = 1'b0;
		else if (rx_hit)
			rx_ip_d = 1'b1;	// new char beats a read in the same clk
		else if (i_data_read)
			rx_ip_d = 1'b0;

		tx_ip_d = o_tx_ip;
		if (i_chan_reset || i_data_write || i_cmd_rst_txip)
			tx_ip_d = 1'b0;	// buffer refilled or acknowledged
		else if (tx_take && i_tx_ie)
			tx_ip_d = 1'b1;
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rx_first <= 1'b1;
			o_rx_ip <= 1'b0;
			o_tx_ip <= 1'b0;
			o_irq_n <= 1'b1;
		end else begin
			if (i_chan_reset || i_cmd_rx_first)
				rx_first <= 1'b1;
			else if (i_data_read)
				rx_first <= 1'b0;
			o_rx_ip <= rx_ip_d;
			o_tx_ip <= tx_ip_d;
			o_irq_n <= ~(i_mie & (rx_ip_d | tx_ip_d));	// same clk as the ip bits
		end
	end

endmodule

`default_nettype wire

// File: rtl/scc_top.sv
`default_nettype none

module scc_top (
	input wire clk,
	input wire reset_hw,
	input wire i_cs,
	input wire i_we,
	input wire [1:0] i_rs,
	input wire scc_pkg::byte_t i_wdata,
	output scc_pkg::byte_t o_rdata,
	output logic o_irq_n,
	input wire i_rxd,
	output logic o_txd
);

	scc_pkg::byte_t tx_data;
	scc_pkg::byte_t rx_data;
	scc_pkg::char_len_t rx_len;
	scc_pkg::char_len_t tx_len;
	scc_pkg::rx_mode_t rx_mode;
	scc_pkg::time_const_t tc;
	logic tx_valid;
	logic tx_ready;
	logic tx_busy;
	logic rx_valid;
	logic chan_reset;
	logic cmd_rx_first;
	logic cmd_rst_txip;
	logic data_write;
	logic data_read;
	logic rx_en;
	logic two_stop;
	logic tx_en;
	logic tx_ie;
	logic mie;
	logic rx_ip;
	logic tx_ip;

	scc_bus_regs bus_regs_i (
		.clk(clk), .reset_hw(reset_hw),
		.i_cs(i_cs), .i_we(i_we), .i_rs(i_rs), .i_wdata(i_wdata),
		.i_rx_valid(rx_valid), .i_rx_data(rx_data),
		.i_tx_ready(tx_ready), .i_tx_busy(tx_busy),
		.i_rx_ip(rx_ip), .i_tx_ip(tx_ip),
		.o_rdata(o_rdata), .o_tx_valid(tx_valid), .o_tx_data(tx_data),
		.o_chan_reset(chan_reset), .o_cmd_rx_first(cmd_rx_first),
		.o_cmd_rst_txip(cmd_rst_txip), .o_data_write(data_write), .o_data_read(data_read),
		.o_rx_en(rx_en), .o_rx_len(rx_len), .o_rx_mode(rx_mode), .o_two_stop(two_stop),
		.o_tx_en(tx_en), .o_tx_len(tx_len), .o_tx_ie(tx_ie), .o_mie(mie), .o_tc(tc)
	);

	scc_irq irq_i (
		.clk(clk), .reset_hw(reset_hw),
		.i_rx_avail_set(rx_valid), .i_data_read(data_read), .i_data_write(data_write),
		.i_cmd_rx_first(cmd_rx_first), .i_cmd_rst_txip(cmd_rst_txip),
		.i_chan_reset(chan_reset), .i_rx_en(rx_en), .i_rx_mode(rx_mode),
		.i_tx_ie(tx_ie), .i_mie(mie), .i_tx_valid(tx_valid), .i_tx_ready(tx_ready),
		.o_rx_ip(rx_ip), .o_tx_ip(tx_ip), .o_irq_n(o_irq_n)
	);

	scc_rx rx_i (
		.clk(clk), .reset_hw(reset_hw),
		.i_rxd(i_rxd), .i_chan_reset(chan_reset), .i_rx_en(rx_en),
		.i_rx_len(rx_len), .i_tc(tc),
		.o_rx_valid(rx_valid), .o_rx_data(rx_data)
	);

	scc_tx tx_i (
		.clk(clk), .reset_hw(reset_hw),
		.i_tx_valid(tx_valid), .i_tx_data(tx_data), .i_chan_reset(chan_reset),
		.i_tx_en(tx_en), .i_tx_len(tx_len), .i_two_stop(two_stop), .i_tc(tc),
		.o_tx_ready(tx_ready), .o_tx_busy(tx_busy), .o_txd(o_txd)
	);

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;	// free running, 50% duty
	end

endmodule

`default_nettype wire

// File: testbench/tb_scc.sv
`default_nettype none
`include "scc_defs.svh"

module tb_scc;

	localparam int WAIT_LIMIT = 2000;	// loop bound for every wait

	logic clk;
	logic reset_hw;
	logic i_cs;
	logic i_we;
	logic [1:0] i_rs;
	scc_pkg::byte_t i_wdata;
	scc_pkg::byte_t o_rdata;
	logic o_irq_n;
	logic i_rxd;
	logic o_txd;

	integer seed;
	integer fd;
	integer n_cases;
	integer n_checks;
	integer n_errors;
	integer bit_clks;	// 2*(tc+2) clocks per serial bit
	logic [8*16-1:0] kind;
	logic [8*24-1:0] case_name;
	scc_pkg::time_const_t tc;
	scc_pkg::byte_t wr1;
	scc_pkg::byte_t wr3;
	scc_pkg::byte_t wr4;
	scc_pkg::byte_t wr5;
	scc_pkg::byte_t wr9;
	scc_pkg::byte_t data;
	scc_pkg::byte_t exp_data;	// byte after masking to the char length

	tb_clock #(.PERIOD(8)) clock_i (.clk(clk));

	scc_top dut_i (
		.clk(clk), .reset_hw(reset_hw), .i_cs(i_cs), .i_we(i_we), .i_rs(i_rs),
		.i_wdata(i_wdata), .o_rdata(o_rdata), .o_irq_n(o_irq_n),
		.i_rxd(i_rxd), .o_txd(o_txd)
	);

	task automatic fail_plain(input logic [8*48-1:0] msg);
		n_errors++;
		$display("%0s: %0s", case_name, msg);
	endtask

	task automatic check_byte(input logic [8*24-1:0] what, input scc_pkg::byte_t exp,
			input scc_pkg::byte_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("ERROR %0s %0s: expected %02h, actual %02h", case_name, what, exp, act);
		end
	endtask

	task automatic check_flag(input logic [8*24-1:0] what, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("ERROR %0s %0s: expected %b, actual %b", case_name, what, exp, act);
		end
	endtask

	// one bus cycle with cs high, read data taken mid cycle
	task automatic bus_access(input logic we, input logic [1:0] rs, input scc_pkg::byte_t wd,
			output scc_pkg::byte_t rd);
		@(posedge clk);
		#1;
		i_cs = 1'b1;
		i_we = we;
		i_rs = rs;
		i_wdata = wd;
		@(negedge clk);
		rd = o_rdata;
		@(posedge clk);
		#1;
		i_cs = 1'b0;	// idle cycle follows, pointer moves then
		i_we = 1'b0;
	endtask

	task automatic bus_write(input logic [1:0] rs, input scc_pkg::byte_t wd);
		scc_pkg::byte_t unused;
		bus_access(1'b1, rs, wd, unused);
	endtask

	task automatic bus_read(input logic [1:0] rs, output scc_pkg::byte_t rd);
		bus_access(1'b0, rs, 8'h00, rd);
	endtask

	// wr0 value that points at register r, point high for 8..15
	function automatic scc_pkg::byte_t pointer_cmd(input scc_pkg::reg_index_t r);
		pointer_cmd = {2'b00, (r[3] ? `SCC_CMD_POINT_HI : 3'b000), r[2:0]};
	endfunction

	task automatic reg_write(input scc_pkg::reg_index_t r, input scc_pkg::byte_t v);
		if (r != `SCC_R_WR0)
			bus_write(2'b01, pointer_cmd(r));
		bus_write(2'b01, v);	// control side of channel a
	endtask

	task automatic reg_read(input scc_pkg::reg_index_t r, output scc_pkg::byte_t rd);
		if (r != `SCC_R_RR0)
			bus_write(2'b01, pointer_cmd(r));
		bus_read(2'b01, rd);
	endtask

	task automatic poll_reg(input scc_pkg::reg_index_t r, input int pos,
			input logic [8*48-1:0] msg);
		scc_pkg::byte_t rd;
		int n;
		n = 0;
		rd = '0;
		while (rd[pos] !== 1'b1 && n < WAIT_LIMIT) begin
			reg_read(r, rd);
			n++;
		end
		if (rd[pos] !== 1'b1)
			fail_plain(msg);
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (o_irq_n !== level && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (o_irq_n !== level)
			fail_plain("timed out waiting for the irq line to change");
	endtask

	// scc bits/char code, 01 means seven
	function automatic int char_len(input logic [1:0] enc);
		case (enc)
			2'b00: char_len = 5;
			2'b01: char_len = 7;
			2'b10: char_len = 6;
			default: char_len = 8;
		endcase
	endfunction

	// async frame on i_rxd, one stop bit, random idle before it
	task automatic send_frame(input scc_pkg::byte_t d, input int nbits);
		int gap;
		gap = ($random(seed) & 15) + 2;
		repeat (gap) @(posedge clk);
		#1 i_rxd = 1'b0;	// start
		repeat (bit_clks) @(posedge clk);
		for (int i = 0; i < nbits; i++) begin
			#1 i_rxd = d[i];	// lsb first
			repeat (bit_clks) @(posedge clk);
		end
		#1 i_rxd = 1'b1;
		repeat (bit_clks) @(posedge clk);
	endtask

	// samples every bit at mid-bit and again on its last clock
	task automatic monitor_frame(input scc_pkg::byte_t exp, input int nbits, input int stops);
		scc_pkg::byte_t got;
		logic mid;
		int n;
		got = '0;
		n = 0;
		@(negedge clk);
		while (o_txd !== 1'b0 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (o_txd !== 1'b0) begin
			fail_plain("timed out waiting for a start bit on the tx line");
		end else begin
			for (int i = 0; i < nbits + stops + 1; i++) begin
				repeat (bit_clks / 2) @(negedge clk);
				mid = o_txd;
				repeat (bit_clks / 2 - 1) @(negedge clk);
				if (o_txd !== mid)
					fail_plain("tx line changed before the bit time ended");
				@(negedge clk);
				if (i == 0)
					check_flag("start bit", 1'b0, mid);
				else if (i <= nbits)
					got[i-1] = mid;
				else
					check_flag("stop bit", 1'b1, mid);
			end
			check_byte("tx data", exp, got);
		end
	endtask

	task automatic read_rx_data();
		scc_pkg::byte_t rd;
		bus_read(2'b11, rd);	// data read of a, clears rx available
		check_byte("rx data", exp_data, rd);
	endtask

	// hardware reset command, then the case's register image
	task automatic setup_regs();
		reg_write(`SCC_R_WR9, {`SCC_RST_HW, 6'b000000});
		reg_write(`SCC_R_TC_LO, tc[7:0]);
		reg_write(`SCC_R_TC_HI, tc[15:8]);
		reg_write(`SCC_R_WR4, wr4);
		reg_write(`SCC_R_WR3, wr3);
		reg_write(`SCC_R_WR1, wr1);
		reg_write(`SCC_R_WR5, wr5);
		reg_write(`SCC_R_WR9, wr9 & 8'h3f);	// no reset bits here
	endtask

	task automatic run_case();
		scc_pkg::byte_t rd;
		int tx_bits;
		int rx_bits;
		int stops;
		logic idle;
		tx_bits = char_len(wr5[`SCC_WR5_BITS_LO +: 2]);
		rx_bits = char_len(wr3[`SCC_WR3_BITS_LO +: 2]);
		stops = (wr4[`SCC_WR4_STOP_LO +: 2] == 2'b11) ? 2 : 1;
		bit_clks = 2 * (tc + 2);
		idle = 1'b1;
		setup_regs();
		case (kind)
			"reg": begin
				reg_read(`SCC_R_TC_LO, rd);	// reached through point high
				check_byte("tc low", tc[7:0], rd);
				reg_read(`SCC_R_TC_HI, rd);
				check_byte("tc high", tc[15:8], rd);
				bus_read(2'b01, rd);	// pointer is back at 0
				check_byte("rr0", exp_data, rd);
			end
			"tx": begin
				bus_write(2'b11, data);
				monitor_frame(exp_data, tx_bits, stops);
				poll_reg(`SCC_R_RR1, 0, "all sent never came back after the frame");
			end
			"rx": begin
				send_frame(data, rx_bits);
				poll_reg(`SCC_R_RR0, 0, "rx available never set after a frame");
				read_rx_data();
				reg_read(`SCC_R_RR0, rd);
				check_flag("rx avail cleared", 1'b0, rd[0]);
			end
			"rxall": begin
				repeat (2) begin
					send_frame(data, rx_bits);
					wait_irq(1'b0);
					read_rx_data();
					@(negedge clk);
					check_flag("irq after read", 1'b1, o_irq_n);
				end
			end
			"rxfirst": begin
				send_frame(data, rx_bits);
				wait_irq(1'b0);
				read_rx_data();
				send_frame(data, rx_bits);	// second char stays quiet
				poll_reg(`SCC_R_RR0, 0, "rx available never set after a frame");
				check_flag("irq on second char", 1'b1, o_irq_n);
				read_rx_data();
				reg_write(`SCC_R_WR0, {2'b00, `SCC_CMD_RX_FIRST, 3'b000});
				send_frame(data, rx_bits);
				wait_irq(1'b0);
				read_rx_data();
			end
			"rxnomie": begin
				send_frame(data, rx_bits);
				poll_reg(`SCC_R_RR0, 0, "rx available never set after a frame");
				check_flag("irq with mie off", 1'b1, o_irq_n);
				reg_read(`SCC_R_RR3, rd);
				check_flag("rr3 rx ip", 1'b1, rd[5]);
				read_rx_data();
			end
			"txirq": begin
				bus_write(2'b11, data);
				wait_irq(1'b0);	// buffer taken by the shifter
				reg_read(`SCC_R_RR3, rd);
				check_flag("rr3 tx ip", 1'b1, rd[4]);
				reg_write(`SCC_R_WR0, {2'b00, `SCC_CMD_RST_TXIP, 3'b000});
				@(negedge clk);
				check_flag("irq after rst txip", 1'b1, o_irq_n);
				bus_write(2'b11, data);	// waits behind the first char
				wait_irq(1'b0);
				bus_write(2'b11, data);
				@(negedge clk);
				check_flag("irq after data write", 1'b1, o_irq_n);
			end
			"chanrst": begin
				reg_write(`SCC_R_WR9, {`SCC_RST_CHAN_A, 6'b000000});
				bus_write(2'b11, data);
				repeat (bit_clks * 12) begin
					@(negedge clk);
					if (o_txd !== 1'b1)
						idle = 1'b0;
				end
				check_flag("txd idle", 1'b1, idle);
				reg_read(`SCC_R_TC_LO, rd);	// tc survives a channel reset
				check_byte("tc low kept", tc[7:0], rd);
				reg_read(`SCC_R_TC_HI, rd);
				check_byte("tc high kept", tc[15:8], rd);
			end
			default: fail_plain("unknown case kind in the case file");
		endcase
	endtask

	initial begin
		int r;
		int c;
		int errs_before;
		seed = 70255;
		reset_hw = 1'b1;
		i_cs = 1'b0;
		i_we = 1'b0;
		i_rs = 2'b00;
		i_wdata = '0;
		i_rxd = 1'b1;	// line idles at mark
		n_cases = 0;
		n_checks = 0;
		n_errors = 0;
		bit_clks = 4;
		case_name = "startup";
		repeat (16) @(posedge clk);
		#1 reset_hw = 1'b0;
		fd = $fopen("testbench/scc_cases.txt", "r");
		if (fd == 0) begin
			fail_plain("could not open testbench/scc_cases.txt");
		end else begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				if (kind == "#") begin
					c = $fgetc(fd);	// comment runs to end of line
					while (c != "\n" && c != -1)
						c = $fgetc(fd);
				end else begin
					r = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", case_name, tc,
						wr1, wr3, wr4, wr5, wr9, data, exp_data);
					if (r != 9) begin
						fail_plain("a line of the case file is malformed");
					end else begin
						errs_before = n_errors;
						run_case();
						n_cases++;
						$display("case %0s (%0s): %0s", case_name, kind,
							(n_errors == errs_before) ? "ok" : "mismatch");
					end
				end
			end
			$fclose(fd);
		end
		if (n_cases == 0)
			fail_plain("no cases were run");
		$display("%0d cases, %0d checks, %0d errors", n_cases, n_checks, n_errors);
		if (n_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/scc_cases.txt
# kind name tc wr1 wr3 wr4 wr5 wr9 data expected, all numbers hex
# expected is rr0 for reg, else the data byte masked to the char length
reg ptr_tc_readback a55a 00 00 00 00 00 00 04
reg ptr_tc_mixed 0102 00 00 00 00 00 00 04
tx tx_8bit_1stop 0002 00 00 04 68 00 a5 a5
tx tx_5bit_2stop 0001 00 00 0c 08 00 f3 13
tx tx_7bit_1stop 0003 00 00 04 28 00 c6 46
tx tx_6bit_2stop 0000 00 00 0c 48 00 5a 1a
tx tx_8bit_2stop 0001 00 00 0c 68 00 3c 3c
# receive, wr3 bit 0 enables the receiver
rx rx_8bit 0002 00 c1 04 00 00 3c 3c
rx rx_5bit 0001 00 01 04 00 00 f5 15
rx rx_7bit 0002 00 41 04 00 00 b9 39
rx rx_6bit 0003 00 81 04 00 00 e7 27
rx rx_8bit_slow 0005 00 c1 04 00 00 81 81
# interrupts, wr1 [4:3] rx mode, wr1 bit 1 tx ie, wr9 bit 3 mie
rxall irq_all_chars 0001 10 c1 04 00 08 81 81
rxall irq_all_5bit 0002 10 01 04 00 08 ee 0e
rxfirst irq_first_char 0002 08 c1 04 00 08 7e 7e
rxnomie irq_mie_off 0001 10 c1 04 00 00 55 55
txirq tx_buffer_irq 0001 02 00 04 68 08 96 96
txirq tx_buffer_irq_2stop 0002 02 00 0c 68 08 69 69
# channel reset drops the tx enable, tc stays
chanrst chan_reset_tx 0002 00 00 04 68 00 0f 0f
chanrst chan_reset_tc 1234 00 00 04 68 00 f0 f0

// File: vlog.f
+incdir+rtl
rtl/scc_pkg.sv
rtl/scc_bus_regs.sv
rtl/scc_tx.sv
rtl/scc_rx.sv
rtl/scc_irq.sv
rtl/scc_top.sv
testbench/tb_clock.sv
testbench/tb_scc.sv
